// ==== all.f ====
gnn_pkg.sv
nb_req_if.sv
nb_bank_if.sv
nb_req_fifo.sv
nb_info_cntl.sv
nb_info_bank.sv
nb_info_merge.sv
nb_info_top.sv
nb_info_props.sv
tb_nb_info.sv

// ==== Makefile ====
TOP = tb_nb_info

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

obj_dir/V$(TOP): all.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== tb_nb_info.sv ====
`timescale 1ns/1ns

module tb_nb_info;
    import gnn_pkg::*;

    logic     clk = 1'b0;
    logic     rst_n;
    iter_t    replay_iter;
    logic     in_valid;
    logic     in_ready;
    node_id_t in_node_id;
    pe_tag_t  in_pe_tag;
    logic     load_valid;
    iter_t    load_iter;
    node_id_t load_node_id;
    nb_addr_t load_data;
    logic     out_valid;
    logic     out_ready;
    nb_addr_t out_addr;
    pe_tag_t  out_pe_tag;

    nb_addr_t    model [MAX_REPLAY_ITER][1 << NODE_ID_W];
    nb_addr_t    exp_addr [$];
    pe_tag_t     exp_tag [$];
    logic [31:0] rng;
    int          ready_mode;   // 0 ready, 1 stalled, 2 random
    int          mismatches;
    int          failures;
    int          accepted;

    nb_info_top DUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic nb_addr_t ref_addr(input iter_t it, input node_id_t node);
        return model[it][node];
    endfunction

    task automatic check_addr(input nb_addr_t exp, input nb_addr_t act);
        if (exp !== act) begin
            $display("Mismatch out_addr: expected %h, got %h", exp, act);
            mismatches++;
        end
    endtask

    task automatic check_tag(input pe_tag_t exp, input pe_tag_t act);
        if (exp !== act) begin
            $display("Mismatch out_pe_tag: expected %h, got %h", exp, act);
            mismatches++;
        end
    endtask

    // One clock, then inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
        if (ready_mode == 2) begin
            rng       = xorshift32(rng);
            out_ready = rng[0];
        end else begin
            out_ready = (ready_mode == 0);
        end
    endtask

    task automatic load_word(input iter_t it, input node_id_t node, input nb_addr_t data);
        load_valid   = 1'b1;
        load_iter    = it;
        load_node_id = node;
        load_data    = data;
        model[it][node] = data;
        step();
        load_valid = 1'b0;
    endtask

    task automatic send_req(input node_id_t node, input pe_tag_t tag);
        int waited;
        waited     = 0;
        in_valid   = 1'b1;
        in_node_id = node;
        in_pe_tag  = tag;
        while (!in_ready && waited < 1000) begin
            step();
            waited++;
        end
        if (in_ready) begin
            exp_addr.push_back(ref_addr(replay_iter, node));
            exp_tag.push_back(tag);
        end else begin
            $display("Timed out waiting for in_ready on node %0d", node);
            failures++;
        end
        step();
        in_valid = 1'b0;
    endtask

    task automatic random_gap();
        rng = xorshift32(rng);
        if (rng[2:1] == 2'b00) begin
            repeat (rng[4:3] + 1) step();
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_addr.size() != 0 && waited < 1000) begin
            step();
            waited++;
        end
        if (exp_addr.size() != 0) begin
            $display("Timed out with %0d results never delivered", exp_addr.size());
            failures++;
            exp_addr.delete();
            exp_tag.delete();
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_addr.size() == 0) begin
                $display("Output appeared with no request pending");
                failures++;
            end else begin
                check_addr(exp_addr.pop_front(), out_addr);
                check_tag(exp_tag.pop_front(), out_pe_tag);
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        replay_iter = '0;
        in_valid    = 1'b0;
        in_node_id  = '0;
        in_pe_tag   = '0;
        load_valid  = 1'b0;
        load_iter   = '0;
        load_node_id = '0;
        load_data   = '0;
        out_ready   = 1'b1;
        ready_mode  = 0;
        mismatches  = 0;
        failures    = 0;
        rng         = 32'h9c64;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        for (int n = 0; n < (1 << NODE_ID_W); n++) begin
            rng = xorshift32(rng);
            load_word('0, node_id_t'(n), rng[NB_INFO_W-1:0]);
        end
        for (int n = 0; n < (1 << NODE_ID_W); n++) begin
            rng = xorshift32(rng);
            send_req(node_id_t'(n), rng[PE_TAG_W-1:0]);
        end
        wait_idle();

        // Alternating banks, then all even, then all odd
        for (int i = 0; i < 32; i++) send_req(node_id_t'(i + 64), pe_tag_t'(i));
        for (int i = 0; i < 16; i++) send_req(node_id_t'(2 * i + 128), pe_tag_t'(i));
        for (int i = 0; i < 16; i++) send_req(node_id_t'(2 * i + 129), pe_tag_t'(i));
        wait_idle();

        for (int it = 1; it < MAX_REPLAY_ITER; it++) begin
            for (int n = 0; n < (1 << NODE_ID_W); n++) begin
                rng = xorshift32(rng);
                load_word(iter_t'(it), node_id_t'(n), rng[NB_INFO_W-1:0]);
            end
        end
        ready_mode = 2;
        for (int it = 1; it < MAX_REPLAY_ITER; it++) begin
            replay_iter = iter_t'(it);   // Only changed while idle
            for (int i = 0; i < 48; i++) begin
                rng = xorshift32(rng);
                send_req(rng[7:0], rng[9:8]);
                random_gap();
            end
            wait_idle();
        end
        replay_iter = '0;

        for (int r = 0; r < 3; r++) begin
            ready_mode = 1;
            out_ready  = 1'b0;
            accepted   = 0;
            in_valid   = 1'b1;
            rng        = xorshift32(rng);
            in_node_id = rng[7:0];
            in_pe_tag  = rng[9:8];
            for (int c = 0; c < 20 && in_ready; c++) begin
                exp_addr.push_back(ref_addr(replay_iter, in_node_id));
                exp_tag.push_back(in_pe_tag);
                accepted++;
                step();
                rng        = xorshift32(rng);
                in_node_id = rng[7:0];
                in_pe_tag  = rng[9:8];
            end
            in_valid = 1'b0;
            if (in_ready) begin
                $display("in_ready stayed high while the output was stalled");
                failures++;
            end else if (accepted > REQ_FIFO_DEPTH + OUT_BUF_DEPTH) begin
                $display("in_ready dropped only after %0d transfers", accepted);
                failures++;
            end
            repeat (rng[3:0] + 2) step();
            ready_mode = 2;
            wait_idle();
        end

        // Fresh words for iteration 0 between bursts
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 8; i++) begin
                rng = xorshift32(rng);
                load_word('0, rng[7:0], rng[24:8]);
            end
            for (int i = 0; i < 24; i++) begin
                rng = xorshift32(rng);
                send_req(rng[7:0], rng[9:8]);
                random_gap();
            end
            wait_idle();
        end

        repeat (5) step();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== nb_info_props.sv ====
`timescale 1ns/1ns

module nb_info_props (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input logic              in_ready,
    input logic              fifo_pop,
    input logic              out_valid,
    input logic              out_ready,
    input gnn_pkg::nb_addr_t out_addr,
    input gnn_pkg::pe_tag_t  out_pe_tag
);
    import gnn_pkg::*;

    logic [REQ_CNT_W-1:0] held;   // Requests in the FIFO, counted from its handshakes

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= '0;
        end else begin
            held <= held + REQ_CNT_W'(in_valid && in_ready) - REQ_CNT_W'(fifo_pop);
        end
    end

    reset_out_low: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("out_valid high in the first cycle after reset");

    // Output held steady under back-pressure
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_addr) && $stable(out_pe_tag))
        else $error("output changed while stalled");

    full_no_ready: assert property (@(posedge clk) disable iff (!rst_n)
        held == REQ_CNT_W'(REQ_FIFO_DEPTH) |-> !in_ready)
        else $error("in_ready high with the request FIFO full");

endmodule

bind nb_info_top nb_info_props props_u (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .fifo_pop   (fifo_u.pop),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_addr   (out_addr),
    .out_pe_tag (out_pe_tag)
);

// ==== nb_info_top.sv ====
`timescale 1ns/1ns

module nb_info_top (
    input  logic              clk,
    input  logic              rst_n,
    input  gnn_pkg::iter_t    replay_iter,
    input  logic              in_valid,
    output logic              in_ready,
    input  gnn_pkg::node_id_t in_node_id,
    input  gnn_pkg::pe_tag_t  in_pe_tag,
    input  logic              load_valid,
    input  gnn_pkg::iter_t    load_iter,
    input  gnn_pkg::node_id_t load_node_id,
    input  gnn_pkg::nb_addr_t load_data,
    output logic              out_valid,
    input  logic              out_ready,
    output gnn_pkg::nb_addr_t out_addr,
    output gnn_pkg::pe_tag_t  out_pe_tag
);
    import gnn_pkg::*;

    nb_req_t in_req;
    logic    issue_valid;
    logic    issue_bank;
    pe_tag_t issue_pe_tag;
    logic    issue_ready;

    nb_req_if  req_bus ();
    nb_bank_if bank0_bus ();
    nb_bank_if bank1_bus ();

    assign in_req.node_id = in_node_id;
    assign in_req.pe_tag  = in_pe_tag;

    nb_req_fifo fifo_u (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (in_valid),
        .wr_ready (in_ready),
        .wr_data  (in_req),
        .rd       (req_bus.src)
    );

    nb_info_cntl cntl_u (
        .clk          (clk),
        .rst_n        (rst_n),
        .replay_iter  (replay_iter),
        .req          (req_bus.dst),
        .load_valid   (load_valid),
        .load_iter    (load_iter),
        .load_node_id (load_node_id),
        .load_data    (load_data),
        .bank0        (bank0_bus.cntl),
        .bank1        (bank1_bus.cntl),
        .issue_valid  (issue_valid),
        .issue_bank   (issue_bank),
        .issue_pe_tag (issue_pe_tag),
        .issue_ready  (issue_ready)
    );

    nb_info_bank bank0_u (.clk(clk), .mem(bank0_bus.bank));   // Even node ids
    nb_info_bank bank1_u (.clk(clk), .mem(bank1_bus.bank));

    nb_info_merge merge_u (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_bank   (issue_bank),
        .issue_pe_tag (issue_pe_tag),
        .issue_ready  (issue_ready),
        .bank0_rdata  (bank0_bus.rdata),
        .bank1_rdata  (bank1_bus.rdata),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_addr     (out_addr),
        .out_pe_tag   (out_pe_tag)
    );

endmodule

// ==== nb_info_merge.sv ====
`timescale 1ns/1ns

module nb_info_merge (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  logic              issue_bank,
    input  gnn_pkg::pe_tag_t  issue_pe_tag,
    output logic              issue_ready,
    input  gnn_pkg::nb_addr_t bank0_rdata,
    input  gnn_pkg::nb_addr_t bank1_rdata,
    output logic              out_valid,
    input  logic              out_ready,
    output gnn_pkg::nb_addr_t out_addr,
    output gnn_pkg::pe_tag_t  out_pe_tag
);
    import gnn_pkg::*;

    logic                 inflight_q;     // Bank read under way
    logic                 inflight_bank_q;
    pe_tag_t              inflight_tag_q;
    nb_addr_t             buf_addr [OUT_BUF_DEPTH];
    pe_tag_t              buf_tag  [OUT_BUF_DEPTH];
    logic [OUT_PTR_W-1:0] wr_ptr;
    logic [OUT_PTR_W-1:0] rd_ptr;
    logic [OUT_CNT_W-1:0] count;
    logic [OUT_CNT_W:0]   occupancy;
    logic                 push;
    logic                 pop;

    // Room is reserved for the read still in flight
    assign occupancy   = {1'b0, count} + {{OUT_CNT_W{1'b0}}, inflight_q};
    assign issue_ready = (occupancy < (OUT_CNT_W+1)'(OUT_BUF_DEPTH));

    assign push = inflight_q;
    assign pop  = out_valid && out_ready;

    assign out_valid  = (count != '0);
    assign out_addr   = buf_addr[rd_ptr];
    assign out_pe_tag = buf_tag[rd_ptr];

    always_ff @(posedge clk) begin
        inflight_bank_q <= issue_bank;
        inflight_tag_q  <= issue_pe_tag;
        if (push) begin
            buf_addr[wr_ptr] <= inflight_bank_q ? bank1_rdata : bank0_rdata;
            buf_tag[wr_ptr]  <= inflight_tag_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inflight_q <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
        end else begin
            inflight_q <= issue_valid && issue_ready;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== nb_info_bank.sv ====
`timescale 1ns/1ns

module nb_info_bank (
    input  logic     clk,
    nb_bank_if.bank  mem
);
    import gnn_pkg::*;

    nb_addr_t words [BANK_DEPTH];

    // Single port, write or read per cycle
    always_ff @(posedge clk) begin
        if (mem.en) begin
            if (mem.we) begin
                words[mem.addr] <= mem.wdata;
            end else begin
                mem.rdata <= words[mem.addr];   // Held until the next read
            end
        end
    end

endmodule

// ==== nb_info_cntl.sv ====
`timescale 1ns/1ns

module nb_info_cntl (
    input  logic              clk,
    input  logic              rst_n,
    input  gnn_pkg::iter_t    replay_iter,
    nb_req_if.dst             req,
    input  logic              load_valid,
    input  gnn_pkg::iter_t    load_iter,
    input  gnn_pkg::node_id_t load_node_id,
    input  gnn_pkg::nb_addr_t load_data,
    nb_bank_if.cntl           bank0,
    nb_bank_if.cntl           bank1,
    output logic              issue_valid,
    output logic              issue_bank,
    output gnn_pkg::pe_tag_t  issue_pe_tag,
    input  logic              issue_ready
);
    import gnn_pkg::*;

    logic                load_bank;
    logic                req_bank;
    bank_addr_t          load_addr;
    bank_addr_t          req_addr;
    logic                stall;
    logic                fire;
    logic [NUM_BANK-1:0] load_hold_q;   // Bank written in the last cycle

    // Low node id bit interleaves the banks
    assign load_bank = load_node_id[0];
    assign req_bank  = req.node_id[0];
    assign load_addr = {load_iter, load_node_id[NODE_ID_W-1:1]};
    assign req_addr  = {replay_iter, req.node_id[NODE_ID_W-1:1]};

    // Load wins, and the next cycle keeps reads off the bank just written
    assign stall = load_valid || load_hold_q[req_bank];

    assign issue_valid  = req.valid && !stall;
    assign issue_bank   = req_bank;
    assign issue_pe_tag = req.pe_tag;
    assign req.ready    = issue_ready && !stall;
    assign fire         = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_hold_q <= '0;
        end else begin
            load_hold_q <= '0;
            if (load_valid) begin
                load_hold_q[load_bank] <= 1'b1;
            end
        end
    end

    assign bank0.en    = (load_valid && !load_bank) || (fire && !req_bank);
    assign bank0.we    = load_valid && !load_bank;
    assign bank0.addr  = load_valid ? load_addr : req_addr;
    assign bank0.wdata = load_data;

    assign bank1.en    = (load_valid && load_bank) || (fire && req_bank);
    assign bank1.we    = load_valid && load_bank;
    assign bank1.addr  = load_valid ? load_addr : req_addr;
    assign bank1.wdata = load_data;

endmodule

// ==== nb_req_fifo.sv ====
`timescale 1ns/1ns

module nb_req_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_valid,
    output logic             wr_ready,
    input  gnn_pkg::nb_req_t wr_data,
    nb_req_if.src            rd
);
    import gnn_pkg::*;

    nb_req_t              mem [REQ_FIFO_DEPTH];
    logic [REQ_PTR_W-1:0] wr_ptr;
    logic [REQ_PTR_W-1:0] rd_ptr;
    logic [REQ_CNT_W-1:0] count;
    logic                 push;
    logic                 pop;

    assign wr_ready = (count != REQ_CNT_W'(REQ_FIFO_DEPTH));
    assign push     = wr_valid && wr_ready;
    assign pop      = rd.valid && rd.ready;

    // First word falls through to the read side
    assign rd.valid   = (count != '0);
    assign rd.node_id = mem[rd_ptr].node_id;
    assign rd.pe_tag  = mem[rd_ptr].pe_tag;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== nb_bank_if.sv ====
`timescale 1ns/1ns

interface nb_bank_if;
    import gnn_pkg::*;

    logic       en;
    logic       we;      // High with en for a write
    bank_addr_t addr;
    nb_addr_t   wdata;
    nb_addr_t   rdata;   // Valid the cycle after a read

    modport cntl (
        output en, we, addr, wdata,
        input  rdata
    );

    modport bank (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

// ==== nb_req_if.sv ====
`timescale 1ns/1ns

interface nb_req_if;
    import gnn_pkg::*;

    logic     valid;
    logic     ready;
    node_id_t node_id;
    pe_tag_t  pe_tag;

    // FIFO side
    modport src (
        output valid, node_id, pe_tag,
        input  ready
    );

    modport dst (
        input  valid, node_id, pe_tag,
        output ready
    );

endinterface

// ==== gnn_pkg.sv ====
package gnn_pkg;

    localparam int NODE_ID_W       = 8;
    localparam int NUM_EDGE_PE     = 4;
    localparam int PE_TAG_W        = 2;   // log2 of NUM_EDGE_PE
    localparam int MAX_REPLAY_ITER = 4;
    localparam int ITER_W          = 2;   // log2 of MAX_REPLAY_ITER
    localparam int NB_INFO_W       = 17;
    localparam int NUM_BANK        = 2;
    localparam int BANK_ADDR_W     = 9;   // Iteration over node id without bit 0
    localparam int BANK_DEPTH      = 512;
    localparam int REQ_FIFO_DEPTH  = 4;
    localparam int OUT_BUF_DEPTH   = 2;

    // Pointer and count widths
    localparam int REQ_PTR_W = $clog2(REQ_FIFO_DEPTH);
    localparam int REQ_CNT_W = $clog2(REQ_FIFO_DEPTH + 1);
    localparam int OUT_PTR_W = $clog2(OUT_BUF_DEPTH);
    localparam int OUT_CNT_W = $clog2(OUT_BUF_DEPTH + 1);

    typedef logic [NODE_ID_W-1:0]   node_id_t;
    typedef logic [PE_TAG_W-1:0]    pe_tag_t;
    typedef logic [ITER_W-1:0]      iter_t;
    typedef logic [NB_INFO_W-1:0]   nb_addr_t;
    typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

    typedef struct packed {
        node_id_t node_id;
        pe_tag_t  pe_tag;
    } nb_req_t;

endpackage
